/* dct_pkg.sv */
// DCT arithmetic package
package dct_pkg;

    // Row geometry
    localparam int N_POINTS  = 16;
    localparam int HALF      = N_POINTS / 2;
    localparam int SAMPLE_W  = 8;

    // Mirrored sum or difference, one bit over a sample
    localparam int SUM_W     = 9;

    // Full precision product sums, worst case 16 * 255 * 64 plus sign
    localparam int ACC_W     = 21;

    // Coefficients are scaled by 64, dropped again at the output
    localparam int FRAC_BITS = 6;
    localparam int COEF_W    = 13;

    // Table magnitudes fit in 7 bits (64 at most)
    localparam int MAG_BITS  = 7;

    // Quarter wave of the cosine, index is phase in 1/64 turns
    localparam int COS_TABLE [17] = '{
        64, 45, 44, 43, 42, 40, 38, 35, 32, 29, 25, 21, 17, 13, 9, 4, 0
    };

    // Flat weight of X0
    localparam int DC_COEF   = 32;

    // Sample n sits in element n
    typedef logic [N_POINTS-1:0][SAMPLE_W-1:0] sample_row_t;

    // Eight mirrored pairs, read as signed where needed
    typedef logic [HALF-1:0][SUM_W-1:0] pair_vec_t;

    // Eight coefficients of one parity
    typedef logic [HALF-1:0][COEF_W-1:0] half_vec_t;

    // Full output row, element k holds X[k]
    typedef logic [N_POINTS-1:0][COEF_W-1:0] coef_row_t;

    // Product value * C(k,n) by shifts and adds
    // k and n are constants at every call, so only the set bits of the
    // magnitude leave adders behind
    function automatic logic signed [ACC_W-1:0] mul_const(
        input logic signed [ACC_W-1:0] value,
        input int                      k,
        input int                      n
    );
        int                      m;
        int                      mag;
        logic                    neg;
        logic signed [ACC_W-1:0] acc;
        m   = ((2 * n + 1) * k) % 64;
        neg = 1'b0;
        // Fold the phase into the first quadrant and keep the sign
        if (k == 0) begin
            mag = DC_COEF;
        end else if (m <= 16) begin
            mag = COS_TABLE[m];
        end else if (m <= 32) begin
            mag = COS_TABLE[32 - m];
            neg = 1'b1;
        end else if (m <= 48) begin
            mag = COS_TABLE[m - 32];
            neg = 1'b1;
        end else begin
            mag = COS_TABLE[64 - m];
        end
        acc = '0;
        for (int b = 0; b < MAG_BITS; b++) begin
            if (mag[b]) begin
                acc = acc + (value <<< b);
            end
        end
        return neg ? -acc : acc;
    endfunction

endpackage

/* dct_flow_pkg.sv */
// DCT flow control package
package dct_flow_pkg;

    // Rows the source may send before any credit comes back
    localparam int IN_CREDITS = 4;

    // Result rows held at the output
    localparam int FIFO_DEPTH = 4;

    // Counters run 0..15
    localparam int CREDIT_W   = 4;

    // Buffer address width, at least one bit
    localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // Credit and occupancy counter
    typedef logic [CREDIT_W-1:0] credit_cnt_t;

    // Read and write pointers
    typedef logic [PTR_W-1:0] fifo_ptr_t;

endpackage

/* dct_input_butterfly.sv */
// DCT input butterfly
module dct_input_butterfly (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  dct_pkg::sample_row_t in_row,
    output logic                pair_valid,
    output dct_pkg::pair_vec_t  pair_sum,
    output dct_pkg::pair_vec_t  pair_diff
);

    import dct_pkg::*;

    // Zero extended mirrored operands
    logic [SUM_W-1:0] lo_ext [HALF];
    logic [SUM_W-1:0] hi_ext [HALF];

    // Pair n with its mirror 15-n
    always_comb begin
        for (int n = 0; n < HALF; n++) begin
            lo_ext[n] = {1'b0, in_row[n]};
            hi_ext[n] = {1'b0, in_row[N_POINTS-1-n]};
        end
    end

    // Valid flag one cycle behind the input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= in_valid;
        end
    end

    // Sums run 0..510 and use all nine bits unsigned
    // Differences run -255..255, two's complement
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int n = 0; n < HALF; n++) begin
                pair_sum[n]  <= lo_ext[n] + hi_ext[n];
                pair_diff[n] <= lo_ext[n] - hi_ext[n];
            end
        end
    end

endmodule

/* dct_even_part.sv */
// DCT even coefficients
module dct_even_part (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pair_valid,
    input  dct_pkg::pair_vec_t pair_sum,
    output logic               even_valid,
    output dct_pkg::half_vec_t even_out
);

    import dct_pkg::*;

    // Sums widened to accumulator width
    logic signed [ACC_W-1:0] s_ext [HALF];

    // Stage two, fold 8 sums into 4 + 4
    logic signed [ACC_W-1:0] a2 [4];
    logic signed [ACC_W-1:0] b2 [4];

    // Stage three, fold 4 into 2 + 2
    logic signed [ACC_W-1:0] a3 [2];
    logic signed [ACC_W-1:0] b3 [2];

    // Stage four, last fold
    logic signed [ACC_W-1:0] a4;
    logic signed [ACC_W-1:0] b4;

    // Unscaled X[2i], element i
    logic signed [ACC_W-1:0] acc [HALF];

    // Sums are never negative, so zero extend
    always_comb begin
        for (int n = 0; n < HALF; n++) begin
            s_ext[n] = {{(ACC_W-SUM_W){1'b0}}, pair_sum[n]};
        end
    end

    // C(k,n) is symmetric about n = 3.5 for k = 0 mod 4
    // and antisymmetric for k = 2 mod 4
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            a2[n] = s_ext[n] + s_ext[7-n];
            b2[n] = s_ext[n] - s_ext[7-n];
        end
        // Same split again, k = 0 mod 8 against k = 4 mod 8
        for (int n = 0; n < 2; n++) begin
            a3[n] = a2[n] + a2[3-n];
            b3[n] = a2[n] - a2[3-n];
        end
        // X0 against X8
        a4 = a3[0] + a3[1];
        b4 = a3[0] - a3[1];
    end

    always_comb begin
        // DC term
        acc[0] = mul_const(a4, 0, 0);
        // X8
        acc[4] = mul_const(b4, 8, 0);
        // X4 and X12 from the stage three differences
        for (int i = 0; i < 2; i++) begin
            acc[2+4*i] = '0;
            for (int n = 0; n < 2; n++) begin
                acc[2+4*i] = acc[2+4*i] + mul_const(b3[n], 4 + 8 * i, n);
            end
        end
        // X2, X6, X10, X14 from the stage two differences
        for (int i = 0; i < 4; i++) begin
            acc[1+2*i] = '0;
            for (int n = 0; n < 4; n++) begin
                acc[1+2*i] = acc[1+2*i] + mul_const(b2[n], 2 + 4 * i, n);
            end
        end
    end

    // Flag for both halves of the row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            even_valid <= 1'b0;
        end else begin
            even_valid <= pair_valid;
        end
    end

    // Drop the fraction bits, result always fits in COEF_W
    always_ff @(posedge clk) begin
        if (pair_valid) begin
            for (int i = 0; i < HALF; i++) begin
                even_out[i] <= COEF_W'(acc[i] >>> FRAC_BITS);
            end
        end
    end

endmodule

/* dct_odd_part.sv */
// DCT odd coefficients
module dct_odd_part (
    input  logic               clk,
    input  dct_pkg::pair_vec_t pair_diff,
    output dct_pkg::half_vec_t odd_out
);

    import dct_pkg::*;

    // Differences widened with their sign
    logic signed [ACC_W-1:0] d_ext [HALF];

    // One rotation pair per group, four groups per output
    logic signed [ACC_W-1:0] rot [HALF][4];

    // Unscaled X[2i+1], element i
    logic signed [ACC_W-1:0] acc [HALF];

    always_comb begin
        for (int n = 0; n < HALF; n++) begin
            d_ext[n] = ACC_W'($signed(pair_diff[n]));
        end
    end

    // Odd k is antisymmetric about n = 7.5
    // so only the differences take part
    // Each group pairs n with 7-n, as in the rotation butterflies
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            for (int n = 0; n < 4; n++) begin
                rot[i][n] = mul_const(d_ext[n], 2 * i + 1, n)
                          + mul_const(d_ext[7-n], 2 * i + 1, 7 - n);
            end
        end
    end

    // Add up the four rotations
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            acc[i] = '0;
            for (int n = 0; n < 4; n++) begin
                acc[i] = acc[i] + rot[i][n];
            end
        end
    end

    // Free running register, the even part carries the flag
    always_ff @(posedge clk) begin
        for (int i = 0; i < HALF; i++) begin
            odd_out[i] <= COEF_W'(acc[i] >>> FRAC_BITS);
        end
    end

endmodule

/* dct_credit_fifo.sv */
// DCT output buffer with credits
module dct_credit_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_valid,
    input  dct_pkg::half_vec_t even_out,
    input  dct_pkg::half_vec_t odd_out,
    input  logic               out_credit,
    output logic               out_valid,
    output dct_pkg::coef_row_t out_row,
    output logic               in_credit
);

    import dct_pkg::*;
    import dct_flow_pkg::*;

    // Row storage
    coef_row_t   mem [FIFO_DEPTH];

    // Incoming row in index order
    coef_row_t   wr_row;

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;

    // Rows held
    credit_cnt_t occupancy;

    // Rows the sink can still take
    credit_cnt_t out_credits;

    // Wrap also for depths that are not a power of two
    function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
        if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Even and odd halves back into k order
    always_comb begin
        for (int i = 0; i < HALF; i++) begin
            wr_row[2*i]   = even_out[i];
            wr_row[2*i+1] = odd_out[i];
        end
    end

    // Pop whenever a row waits and the sink has room
    assign out_valid = (out_credits != '0) && (occupancy != '0);
    assign out_row   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_row;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            occupancy   <= '0;
            out_credits <= '0;
            in_credit   <= 1'b0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (out_valid) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop in one cycle leave the count alone
            case ({wr_valid, out_valid})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            // Grant and spend in one cycle cancel
            case ({out_credit, out_valid})
                2'b10:   out_credits <= out_credits + 1'b1;
                2'b01:   out_credits <= out_credits - 1'b1;
                default: out_credits <= out_credits;
            endcase
            // Freed slot goes back to the source the cycle after the pop
            in_credit <= out_valid;
        end
    end

endmodule

/* dct_row_top.sv */
// 16 point row DCT
module dct_row_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  dct_pkg::sample_row_t in_row,
    input  logic                 out_credit,
    output logic                 in_credit,
    output logic                 out_valid,
    output dct_pkg::coef_row_t   out_row
);

    import dct_pkg::*;

    // Butterfly to compute stages
    logic      pair_valid;
    pair_vec_t pair_sum;
    pair_vec_t pair_diff;

    // Compute stages to buffer
    logic      even_valid;
    half_vec_t even_out;
    half_vec_t odd_out;

    // Mirrored sums and differences, 1 cycle
    dct_input_butterfly i_butterfly (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_row     (in_row),
        .pair_valid (pair_valid),
        .pair_sum   (pair_sum),
        .pair_diff  (pair_diff)
    );

    // Even k, 1 cycle, owns the row flag
    dct_even_part i_even (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair_valid (pair_valid),
        .pair_sum   (pair_sum),
        .even_valid (even_valid),
        .even_out   (even_out)
    );

    // Odd k, 1 cycle, in step with the even part
    dct_odd_part i_odd (
        .clk       (clk),
        .pair_diff (pair_diff),
        .odd_out   (odd_out)
    );

    // Buffer and both credit loops
    dct_credit_fifo i_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_valid   (even_valid),
        .even_out   (even_out),
        .odd_out    (odd_out),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_row    (out_row),
        .in_credit  (in_credit)
    );

endmodule

/* tb_dct_model.svh */
// DCT reference model
`ifndef TB_DCT_MODEL_SVH
`define TB_DCT_MODEL_SVH

// Weight of sample n in output k, scaled by 64
function automatic int cos_weight(input int k, input int n);
    int mag_table [17];
    int m;
    int f;
    int sgn;
    mag_table = '{64, 45, 44, 43, 42, 40, 38, 35, 32, 29, 25, 21, 17, 13, 9, 4, 0};
    if (k == 0) begin
        return 32;
    end
    m   = ((2 * n + 1) * k) % 64;
    sgn = 1;
    // Fold the phase into 0..16
    if (m <= 16) begin
        f = m;
    end else if (m <= 32) begin
        f   = 32 - m;
        sgn = -1;
    end else if (m <= 48) begin
        f   = m - 32;
        sgn = -1;
    end else begin
        f = 64 - m;
    end
    return sgn * mag_table[f];
endfunction

// Full precision sum, then drop six fraction bits
function automatic coef_row_t dct_model(input sample_row_t row);
    coef_row_t res;
    longint    acc;
    for (int k = 0; k < 16; k++) begin
        acc = 0;
        for (int n = 0; n < 16; n++) begin
            acc = acc + longint'(row[n]) * cos_weight(k, n);
        end
        res[k] = COEF_W'(acc >>> 6);
    end
    return res;
endfunction

// Every sample set to one value
function automatic sample_row_t const_row(input logic [7:0] value);
    sample_row_t row;
    for (int n = 0; n < 16; n++) begin
        row[n] = value;
    end
    return row;
endfunction

// One nonzero sample at pos
function automatic sample_row_t impulse_row(input int pos, input logic [7:0] value);
    sample_row_t row;
    row      = '0;
    row[pos] = value;
    return row;
endfunction

`endif

/* tb_dct_row.sv */
// DCT row testbench
module tb_dct_row;

    import dct_pkg::*;
    import dct_flow_pkg::*;

    `include "tb_dct_model.svh"

    localparam int WAIT_LIMIT = 200;
    localparam int GRANT_MAX  = 8;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    sample_row_t in_row;
    logic        out_credit;
    logic        in_credit;
    logic        out_valid;
    coef_row_t   out_row;

    // Source credits, credits held by the DUT, rows seen, credits returned
    int          src_credits;
    int          out_grants;
    int          pops;
    int          credit_returns;
    coef_row_t   exp_q [$];

    dct_row_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_row     (in_row),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_row    (out_row)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            fail_run($sformatf("CHECK FAILED time=%0t signal=%s actual=%0d expected=%0d",
                               $time, name, actual, expected));
        end
    endtask

    // Score one cycle of DUT outputs against the expected rows
    task automatic observe_outputs();
        coef_row_t expected;
        if (in_credit) begin
            src_credits++;
            credit_returns++;
            check_value("source credits bound", src_credits > IN_CREDITS, 0);
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("out_valid asserted while no row was expected");
            end else if (out_grants == 0) begin
                fail_run("out_valid asserted without an output credit");
            end else begin
                expected = exp_q.pop_front();
                for (int k = 0; k < N_POINTS; k++) begin
                    check_value($sformatf("out_row[%0d]", k),
                                $signed(out_row[k]), $signed(expected[k]));
                end
                out_grants--;
                pops++;
            end
        end
    endtask

    // Drive one cycle at the falling edge, then observe at the next one
    task automatic step_cycle(input logic valid, input sample_row_t row, input logic want_grant);
        logic grant;
        grant      = want_grant && (out_grants < GRANT_MAX);
        in_valid   = valid;
        in_row     = row;
        out_credit = grant;
        if (valid) begin
            src_credits--;
            exp_q.push_back(dct_model(row));
        end
        if (grant) begin
            out_grants++;
        end
        @(negedge clk);
        observe_outputs();
    endtask

    task automatic do_reset();
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_row     = '0;
        out_credit = 1'b0;
        repeat (5) @(negedge clk);
        rst_n          = 1'b1;
        src_credits    = IN_CREDITS;
        out_grants     = 0;
        pops           = 0;
        credit_returns = 0;
        exp_q.delete();
    endtask

    // Idle until the source holds a credit
    task automatic send_row(input sample_row_t row, input logic free);
        int waited;
        waited = 0;
        while (src_credits == 0) begin
            if (waited == WAIT_LIMIT) begin
                fail_run("timed out waiting for an input credit");
            end else begin
                step_cycle(1'b0, '0, free);
                waited++;
            end
        end
        step_cycle(1'b1, row, free);
    endtask

    // All rows out and all input credits back
    task automatic drain(input logic free);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 || src_credits != IN_CREDITS) begin
            if (waited == WAIT_LIMIT) begin
                fail_run("timed out waiting for result rows and returned credits");
            end else begin
                step_cycle(1'b0, '0, free);
                waited++;
            end
        end
    endtask

    function automatic sample_row_t random_row();
        sample_row_t row;
        for (int n = 0; n < N_POINTS; n++) begin
            row[n] = 8'($urandom);
        end
        return row;
    endfunction

    task automatic idle_after_reset();
        do_reset();
        repeat (8) begin
            step_cycle(1'b0, '0, 1'b0);
            check_value("out_valid", out_valid, 0);
            check_value("in_credit", in_credit, 0);
        end
    endtask

    task automatic fixed_rows();
        coef_row_t full;
        // Flat row puts everything in DC
        full = dct_model(const_row(8'd255));
        check_value("model X[0]", $signed(full[0]), 2040);
        for (int k = 1; k < N_POINTS; k++) begin
            check_value($sformatf("model X[%0d]", k), $signed(full[k]), 0);
        end
        send_row(const_row(8'd0), 1'b1);
        send_row(const_row(8'd255), 1'b1);
        send_row(impulse_row(5, 8'd200), 1'b1);
        drain(1'b1);
    endtask

    task automatic random_stream();
        repeat (20) begin
            send_row(random_row(), 1'b1);
        end
        drain(1'b1);
    endtask

    task automatic back_pressure();
        int before_pops;
        int before_ret;
        int waited;
        do_reset();
        repeat (IN_CREDITS) begin
            send_row(random_row(), 1'b0);
        end
        check_value("source credits", src_credits, 0);
        repeat (10) begin
            step_cycle(1'b0, '0, 1'b0);
            check_value("out_valid", out_valid, 0);
            check_value("in_credit", in_credit, 0);
        end
        // One credit, one row, one returned input credit
        for (int i = 0; i < IN_CREDITS; i++) begin
            before_pops = pops;
            before_ret  = credit_returns;
            waited      = 0;
            step_cycle(1'b0, '0, 1'b1);
            while (pops == before_pops) begin
                if (waited == WAIT_LIMIT) begin
                    fail_run("timed out waiting for a row released by a credit");
                end else begin
                    step_cycle(1'b0, '0, 1'b0);
                    waited++;
                end
            end
            repeat (4) step_cycle(1'b0, '0, 1'b0);
            check_value("rows released", pops, before_pops + 1);
            check_value("in_credit pulses", credit_returns, before_ret + 1);
        end
    endtask

    // in_valid taken at one rising edge, out_valid seen three edges later
    task automatic single_row_latency();
        int before_pops;
        int cycles;
        step_cycle(1'b0, '0, 1'b1);
        repeat (2) step_cycle(1'b0, '0, 1'b0);
        before_pops = pops;
        step_cycle(1'b1, random_row(), 1'b0);
        cycles = 1;
        while (pops == before_pops) begin
            if (cycles == WAIT_LIMIT) begin
                fail_run("timed out waiting for out_valid of the latency row");
            end else begin
                step_cycle(1'b0, '0, 1'b0);
                cycles++;
            end
        end
        check_value("out_valid latency", cycles, 3);
        drain(1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_row     = '0;
        out_credit = 1'b0;
        void'($urandom(32'hd1f8));
        idle_after_reset();
        fixed_rows();
        random_stream();
        back_pressure();
        single_row_latency();
        $display("test passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+.
dct_pkg.sv
dct_flow_pkg.sv
dct_input_butterfly.sv
dct_even_part.sv
dct_odd_part.sv
dct_credit_fifo.sv
dct_row_top.sv
tb_dct_row.sv
